// File: processor.f
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/regfile.sv
rtl/fetch_unit.sv
rtl/execute_unit.sv
rtl/pipe_control.sv
rtl/processor.sv
test/tb_mem.sv
test/processor_tb.sv

// File: test/processor_tb.sv
// ----------------------------------------
// Testbench for the pipelined CPU
// Loads one program into the ROM, runs an
// ISA model on it and checks every store
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module processor_tb;
    import instr_enc_pkg::*;

    logic        clock;
    logic        rst_n;
    logic        rst_q;                  // rst_n at the last rising edge
    logic [11:0] address_imem, address_dmem;
    logic [31:0] q_imem, q_dmem, data;
    logic        wren;
    logic [11:0] exp_addr [$];           // Expected stores, oldest first
    logic [31:0] exp_data [$];
    logic [31:0] model_mem [4096];
    logic [31:0] rnd;
    int          load_pc;                // Next free ROM word
    int          store_addr;             // Next sw target
    int          post_cycles = 0;
    int          cycles;

    processor dut0 (.clock, .rst_n, .address_imem, .q_imem, .address_dmem,
                    .data, .wren, .q_dmem);
    inst_rom rom0 (.address(address_imem), .q(q_imem));
    data_ram ram0 (.clock, .address(address_dmem), .data, .wren, .q(q_dmem));

    always #4 clock = ~clock;            // 8 ns period

    always @(posedge clock) rst_q <= rst_n;

    task automatic stop_run(input string msg);
        $display("** Error: %s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] got, exp);
        stop_run($sformatf("%s = %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic emit(input logic [31:0] w);
        rom0.mem[load_pc] = w;
        load_pc++;
    endtask

    task automatic add_store(input int src);
        emit(imm_word(OP_SW, src, 0, store_addr));
        store_addr++;
    endtask

    // Program --------------------------------
    task automatic load_program();
        emit(imm_word(OP_ADDI, 1, 0, 5));
        emit(imm_word(OP_ADDI, 2, 1, 7));      // r1 from xm
        emit(alu_word(AOP_ADD, 3, 1, 2, 0));   // r1 from mw, r2 from xm
        emit(alu_word(AOP_SUB, 4, 3, 1, 0));
        add_store(4);                          // Store data forwarded
        add_store(3);
        emit(alu_word(AOP_OR, 5, 4, 2, 0));
        emit(imm_word(OP_SW, 5, 2, 290));      // Base in r2
        emit(imm_word(OP_LW, 6, 0, 200));
        emit(alu_word(AOP_ADD, 7, 6, 6, 0));   // Load-use stall
        add_store(7);
        emit(imm_word(OP_LW, 8, 0, 201));
        add_store(8);                          // Load feeds store data
        for (int k = 0; k < 6; k++) begin
            emit(alu_word(5'(k), 9, 6, 8, 7 + k));   // Every ALU op
            add_store(9);
        end
        emit(imm_word(OP_BNE, 1, 1, 3));       // Equal, falls through
        add_store(1);
        emit(imm_word(OP_BNE, 1, 2, 1));       // Taken, skips one
        add_store(2);
        emit(imm_word(OP_BLT, 2, 1, 1));       // 12 < 5 fails
        add_store(3);
        emit(imm_word(OP_BLT, 1, 2, 2));       // Taken, skips two
        add_store(4);
        add_store(4);
        emit(jump_word(OP_J, load_pc + 3));
        add_store(5);
        add_store(5);
        emit(imm_word(OP_BLT, 8, 6, 1));       // Random compare
        add_store(6);
        emit(jump_word(OP_JAL, load_pc + 2));  // Link into r31
        add_store(0);
        add_store(31);
        emit(alu_word(AOP_ADD, 0, 1, 2, 0));   // r0 stays zero
        add_store(0);
        emit(jump_word(OP_J, load_pc));        // Park
    endtask

    // ISA model, fills the store scoreboard
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] w, a, b, c, imm, res;
        logic [11:0] pc, ea;
        logic [4:0]  dest;
        logic        wr;
        logic        parked;
        int          steps;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        pc     = '0;
        parked = 1'b0;
        steps  = 0;
        while (!parked && steps < 1000) begin
            w    = rom0.mem[pc];
            a    = regs[w[21:17]];             // rs
            b    = regs[w[16:12]];             // rt
            c    = regs[w[26:22]];             // rd as a source
            dest = w[26:22];
            imm  = {{15{w[16]}}, w[16:0]};
            ea   = 12'(a + imm);
            wr   = 1'b0;
            res  = '0;
            pc   = pc + 12'd1;                 // Branch base and link value
            case (w[31:27])
                OP_ALU: begin
                    wr = 1'b1;
                    case (w[6:2])
                        AOP_SUB: res = a - b;
                        AOP_AND: res = a & b;
                        AOP_OR:  res = a | b;
                        AOP_SLL: res = a << w[11:7];
                        AOP_SRA: res = $signed(a) >>> w[11:7];
                        default: res = a + b;
                    endcase
                end
                OP_ADDI: {wr, res} = {1'b1, a + imm};
                OP_LW:   {wr, res} = {1'b1, model_mem[ea]};
                OP_SW: begin
                    model_mem[ea] = c;
                    exp_addr.push_back(ea);
                    exp_data.push_back(c);
                end
                OP_BNE: if (c != a) pc = pc + imm[11:0];
                OP_BLT: if ($signed(c) < $signed(a)) pc = pc + imm[11:0];
                OP_J: begin
                    parked = (w[11:0] == pc - 12'd1);   // Jump to itself
                    pc     = w[11:0];
                end
                OP_JAL: begin
                    {wr, res, dest} = {1'b1, 32'(pc), 5'd31};
                    pc = w[11:0];
                end
                default: ;
            endcase
            if (wr && dest != 5'd0)
                regs[dest] = res;
            steps++;
        end
        if (!parked)
            stop_run("model never reached the end of the program");
    endtask

    // Checks at the falling edge ---------------
    always @(negedge clock) begin
        if (!rst_q) begin
            assert (address_imem == 12'd0)
                else value_error("address_imem", 32'(address_imem), 32'd0);
            assert (!wren) else value_error("wren", 32'(wren), 32'd0);
        end else begin
            post_cycles++;
            if (post_cycles <= 8) begin        // Straight-line fetch
                assert (address_imem == 12'(post_cycles))
                    else value_error("address_imem", 32'(address_imem), post_cycles);
            end
            if (wren && exp_addr.size() == 0)
                stop_run("store seen with no store left to expect");
            if (wren) begin
                assert (address_dmem == exp_addr[0])
                    else value_error("address_dmem", 32'(address_dmem), 32'(exp_addr[0]));
                assert (data == exp_data[0]) else value_error("data", data, exp_data[0]);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        clock      = 1'b0;
        rst_n      = 1'b0;
        rnd        = 32'h621d_83b4;
        load_pc    = 0;
        store_addr = 310;
        @(negedge clock);
        for (int k = 200; k < 202; k++) begin   // Random load operands
            rnd         = xorshift(rnd);
            ram0.mem[k] = rnd;
        end
        for (int k = 0; k < 4096; k++)
            model_mem[k] = ram0.mem[k];
        load_program();
        run_model();
        repeat (4) @(negedge clock);           // Five rising edges in reset
        rst_n  = 1'b1;
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < 500) begin
            @(negedge clock);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            stop_run("timeout with stores still expected");
        end else begin
            cycles = 0;
            while (cycles < 16) begin          // Stray stores from the park loop
                @(negedge clock);
                cycles++;
            end
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_mem.sv
// ----------------------------------------
// Memory models for the CPU testbench
// ROM and RAM answer in the same cycle, and
// a small package encodes instruction words
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

package instr_enc_pkg;

    // Opcodes and ALU codes as the ISA fixes them
    localparam logic [4:0] OP_ALU  = 5'b00000;
    localparam logic [4:0] OP_J    = 5'b00001;
    localparam logic [4:0] OP_BNE  = 5'b00010;
    localparam logic [4:0] OP_JAL  = 5'b00011;
    localparam logic [4:0] OP_ADDI = 5'b00101;
    localparam logic [4:0] OP_BLT  = 5'b00110;
    localparam logic [4:0] OP_SW   = 5'b00111;
    localparam logic [4:0] OP_LW   = 5'b01000;
    localparam logic [4:0] AOP_ADD = 5'd0;
    localparam logic [4:0] AOP_SUB = 5'd1;
    localparam logic [4:0] AOP_AND = 5'd2;
    localparam logic [4:0] AOP_OR  = 5'd3;
    localparam logic [4:0] AOP_SLL = 5'd4;
    localparam logic [4:0] AOP_SRA = 5'd5;

    // R format, two low bits always zero
    function automatic logic [31:0] alu_word(input logic [4:0] op, input int rd, rs, rt, sh);
        return {OP_ALU, rd[4:0], rs[4:0], rt[4:0], sh[4:0], op, 2'b00};
    endfunction

    function automatic logic [31:0] imm_word(input logic [4:0] op, input int rd, rs, imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};   // 17-bit immediate
    endfunction

    function automatic logic [31:0] jump_word(input logic [4:0] op, input int target);
        return {op, target[26:0]};
    endfunction

endpackage

module inst_rom (
    input  logic [11:0] address,
    output logic [31:0] q
);
    import instr_enc_pkg::*;

    logic [31:0] mem [4096];

    initial begin
        for (int a = 0; a < 4096; a++)
            mem[a] = jump_word(OP_J, a);    // Unused words jump to themselves
    end

    assign q = mem[address];                // Same-cycle read

endmodule

module data_ram (
    input  logic        clock,
    input  logic [11:0] address,
    input  logic [31:0] data,
    input  logic        wren,
    output logic [31:0] q
);
    logic [31:0] mem [4096];

    initial begin
        for (int a = 0; a < 4096; a++)
            mem[a] = {~a[11:0], 8'hc3, a[11:0]};   // Fill tied to the address
    end

    always @(posedge clock) begin
        if (wren)
            mem[address] <= data;
    end

    assign q = mem[address];

endmodule

`default_nettype wire

// File: rtl/processor.sv
// ----------------------------------------
// Five-stage pipelined CPU, top level
// Talks to an external imem ROM and dmem
// RAM, both answering in the same cycle
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module processor (
    input  logic                           clock,
    input  logic                           rst_n,
    output logic [cpu_isa_pkg::ADDR_W-1:0] address_imem,  // Fetch address
    input  logic [cpu_isa_pkg::XLEN-1:0]   q_imem,
    output logic [cpu_isa_pkg::ADDR_W-1:0] address_dmem,  // Load/store address
    output logic [cpu_isa_pkg::XLEN-1:0]   data,          // Store data
    output logic                           wren,
    input  logic [cpu_isa_pkg::XLEN-1:0]   q_dmem
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    fd_reg_t          fd;
    dx_reg_t          dx;
    xm_reg_t          xm;
    mw_reg_t          mw;
    ctrl_t            dec_ctrl;
    fwd_sel_t         fwd_a, fwd_b, fwd_store;
    logic             stall, flush, redirect;
    logic [ADDR_W-1:0] target;
    logic [REG_W-1:0] rd_sel_a, rd_sel_b;
    logic [XLEN-1:0]  rd_data_a, rd_data_b;
    logic [XLEN-1:0]  alu_result, store_data;
    logic [XLEN-1:0]  wb_value;

    // Fetch and decode ------------------------
    fetch_unit fetch0 (.clock, .rst_n, .stall, .flush, .redirect, .target,
                       .q_imem, .address_imem, .fd);

    pipe_control ctrl0 (.clock, .rst_n, .fd, .dx, .xm, .mw, .redirect,
                        .stall, .flush, .dec_ctrl, .rd_sel_a, .rd_sel_b,
                        .fwd_a, .fwd_b, .fwd_store);

    regfile rf0 (.clock, .rst_n, .rd_sel_a, .rd_sel_b,
                 .we(mw.reg_we), .wr_sel(mw.dest), .wr_data(wb_value),
                 .rd_data_a, .rd_data_b);

    always_ff @(posedge clock) begin
        if (!rst_n || flush || stall) begin
            dx       <= '0;           // Bubble, controls cleared
            dx.instr <= NOP_WORD;
        end else begin
            dx <= '{pc: fd.pc, instr: fd.instr, rd_a: rd_data_a,
                     rd_b: rd_data_b, ctrl: dec_ctrl};
        end
    end

    // Execute ---------------------------------
    execute_unit exec0 (.dx, .xm_result(xm.result), .wb_value,
                        .fwd_a, .fwd_b, .fwd_store,
                        .alu_result, .store_data, .redirect, .target);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xm <= '0;
        end else begin
            xm.result     <= alu_result;
            xm.store_data <= store_data;
            xm.dest       <= dx.ctrl.is_jal ? REG_W'(31) : dx.instr.i.rd;  // Link reg
            xm.ctrl       <= dx.ctrl;
        end
    end

    // Memory and writeback --------------------
    assign address_dmem = xm.result[ADDR_W-1:0];
    assign data         = xm.store_data;
    assign wren         = xm.ctrl.mem_we;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mw <= '0;
        end else begin
            mw <= '{result: xm.result, load_data: q_dmem, dest: xm.dest,
                     reg_we: xm.ctrl.reg_we, mem_rd: xm.ctrl.mem_rd};
        end
    end

    assign wb_value = mw.mem_rd ? mw.load_data : mw.result;  // Load data or ALU

endmodule

`default_nettype wire

// File: rtl/pipe_control.sv
// ----------------------------------------
// Decode and hazard control
// Decodes the fd word, picks forwarding
// paths for execute, raises stall and flush
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module pipe_control (
    input  logic                            clock,
    input  logic                            rst_n,
    input  cpu_pipe_pkg::fd_reg_t           fd,
    input  cpu_pipe_pkg::dx_reg_t           dx,
    input  cpu_pipe_pkg::xm_reg_t           xm,
    input  cpu_pipe_pkg::mw_reg_t           mw,
    input  logic                            redirect,   // Taken branch or jump
    output logic                            stall,
    output logic                            flush,
    output cpu_pipe_pkg::ctrl_t             dec_ctrl,
    output logic [cpu_isa_pkg::REG_W-1:0]   rd_sel_a,
    output logic [cpu_isa_pkg::REG_W-1:0]   rd_sel_b,
    output cpu_pipe_pkg::fwd_sel_t          fwd_a,
    output cpu_pipe_pkg::fwd_sel_t          fwd_b,
    output cpu_pipe_pkg::fwd_sel_t          fwd_store
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    opcode_t          fd_op, dx_op;
    logic             hazard;      // Load in dx feeds the fd word
    logic             stall_q;     // Bubble inserted last cycle

    // Port B reads rd for stores and branches, rt otherwise
    function automatic logic [REG_W-1:0] src_b(input instr_u w);
        if (w.r.opcode inside {OP_SW, OP_BNE, OP_BLT})
            return w.i.rd;
        return w.r.rt;
    endfunction

    // Youngest writer wins, r0 never forwarded
    function automatic fwd_sel_t pick(input logic [REG_W-1:0] src, input logic used);
        if (!used || src == '0)
            return FWD_REG;
        if (xm.ctrl.reg_we && xm.dest == src)
            return FWD_MEM;
        if (mw.reg_we && mw.dest == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign fd_op    = fd.instr.r.opcode;
    assign dx_op    = dx.instr.r.opcode;
    assign rd_sel_a = fd.instr.i.rs;
    assign rd_sel_b = src_b(fd.instr);

    // Decode ----------------------------------
    always_comb begin
        dec_ctrl        = '0;
        dec_ctrl.alu_op = ALU_ADD;            // Address and addi default
        case (fd_op)
            OP_ALU:  begin
                dec_ctrl.reg_we = 1'b1;
                dec_ctrl.alu_op = fd.instr.r.alu_op;
            end
            OP_ADDI: {dec_ctrl.reg_we, dec_ctrl.use_imm} = 2'b11;
            OP_LW:   {dec_ctrl.reg_we, dec_ctrl.use_imm, dec_ctrl.mem_rd} = 3'b111;
            OP_SW:   {dec_ctrl.use_imm, dec_ctrl.mem_we} = 2'b11;
            OP_BNE:  dec_ctrl.is_branch_ne = 1'b1;
            OP_BLT:  dec_ctrl.is_branch_lt = 1'b1;
            OP_J:    dec_ctrl.is_jump = 1'b1;
            OP_JAL:  {dec_ctrl.reg_we, dec_ctrl.is_jump, dec_ctrl.is_jal} = 3'b111;
            default: dec_ctrl.reg_we = 1'b0;  // Unknown opcode acts as nop
        endcase
    end

    // Hazards and forwarding ------------------
    always_comb begin
        hazard = dx.ctrl.mem_rd && dx.instr.i.rd != '0 &&
                 ((!(fd_op inside {OP_J, OP_JAL}) && dx.instr.i.rd == rd_sel_a) ||
                  (fd_op inside {OP_ALU, OP_SW, OP_BNE, OP_BLT} &&
                   dx.instr.i.rd == rd_sel_b));
        stall  = hazard && !stall_q;          // One bubble per load
        flush  = redirect;                    // Kill fd and the word in flight

        fwd_a     = pick(dx.instr.i.rs, !(dx_op inside {OP_J, OP_JAL}));
        fwd_b     = pick(src_b(dx.instr), dx_op == OP_ALU);     // ALU rt only
        fwd_store = pick(src_b(dx.instr), dx_op inside {OP_SW, OP_BNE, OP_BLT});
    end

    always_ff @(posedge clock) begin
        if (!rst_n)
            stall_q <= 1'b0;
        else
            stall_q <= stall;
    end

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
// ----------------------------------------
// Execute stage, purely combinational
// Forwarding muxes, ALU, branch compare and
// the redirect target for fetch
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  cpu_pipe_pkg::dx_reg_t          dx,
    input  logic [cpu_isa_pkg::XLEN-1:0]   xm_result,
    input  logic [cpu_isa_pkg::XLEN-1:0]   wb_value,
    input  cpu_pipe_pkg::fwd_sel_t         fwd_a,
    input  cpu_pipe_pkg::fwd_sel_t         fwd_b,
    input  cpu_pipe_pkg::fwd_sel_t         fwd_store,
    output logic [cpu_isa_pkg::XLEN-1:0]   alu_result,
    output logic [cpu_isa_pkg::XLEN-1:0]   store_data,  // Also the rd compare value
    output logic                           redirect,
    output logic [cpu_isa_pkg::ADDR_W-1:0] target
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [XLEN-1:0] op_a, op_b_reg, op_b, imm32, alu_out;
    logic            taken;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return xm_result;
            FWD_WB:  return wb_value;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a       = fwd_mux(fwd_a, dx.rd_a);
        op_b_reg   = fwd_mux(fwd_b, dx.rd_b);
        store_data = fwd_mux(fwd_store, dx.rd_b);
        imm32      = {{(XLEN-17){dx.instr.i.imm[16]}}, dx.instr.i.imm};  // Sign extend
        op_b       = dx.ctrl.use_imm ? imm32 : op_b_reg;

        case (dx.ctrl.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLL: alu_out = op_a << dx.instr.r.shamt;
            ALU_SRA: alu_out = $signed(op_a) >>> dx.instr.r.shamt;
            default: alu_out = op_a + op_b;   // add, addi, lw/sw address
        endcase

        // Branch compares rd against rs
        taken = (dx.ctrl.is_branch_ne && store_data != op_a) ||
                (dx.ctrl.is_branch_lt && $signed(store_data) < $signed(op_a));
        redirect   = dx.ctrl.is_jump || taken;
        target     = dx.ctrl.is_jump ? dx.instr.j.target[ADDR_W-1:0]
                                     : dx.pc + imm32[ADDR_W-1:0];  // PC+1+imm
        alu_result = dx.ctrl.is_jal ? XLEN'(dx.pc) : alu_out;      // Link value
    end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
// ----------------------------------------
// Fetch stage with PC and fd register
// PC steps by one, loads the target on
// redirect and holds while stalled
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           stall,
    input  logic                           flush,
    input  logic                           redirect,
    input  logic [cpu_isa_pkg::ADDR_W-1:0] target,
    input  logic [cpu_isa_pkg::XLEN-1:0]   q_imem,
    output logic [cpu_isa_pkg::ADDR_W-1:0] address_imem,
    output cpu_pipe_pkg::fd_reg_t          fd
);
    import cpu_isa_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pc_plus1;

    assign pc_plus1     = pc + 1'b1;
    assign address_imem = pc;          // ROM answers this cycle

    always_ff @(posedge clock) begin
        if (!rst_n)
            pc <= '0;
        else if (redirect)
            pc <= target;              // Branch or jump from execute
        else if (!stall)
            pc <= pc_plus1;
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            fd.pc    <= '0;
            fd.instr <= NOP_WORD;      // Drop the younger fetch
        end else if (!stall) begin
            fd.pc    <= pc_plus1;      // Link value and branch base
            fd.instr <= q_imem;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
// ----------------------------------------
// 32x32 register file, two reads, one write
// r0 reads zero, writes pass to same-cycle
// reads
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [cpu_isa_pkg::REG_W-1:0] rd_sel_a,
    input  logic [cpu_isa_pkg::REG_W-1:0] rd_sel_b,
    input  logic                          we,
    input  logic [cpu_isa_pkg::REG_W-1:0] wr_sel,
    input  logic [cpu_isa_pkg::XLEN-1:0]  wr_data,
    output logic [cpu_isa_pkg::XLEN-1:0]  rd_data_a,
    output logic [cpu_isa_pkg::XLEN-1:0]  rd_data_b
);
    import cpu_isa_pkg::*;

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int k = 0; k < NREG; k++)
                regs[k] <= '0;
        end else if (we && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;   // r0 is never stored
        end
    end

    // Write-through, decode sees the writeback value
    always_comb begin
        rd_data_a = (we && wr_sel == rd_sel_a) ? wr_data : regs[rd_sel_a];
        rd_data_b = (we && wr_sel == rd_sel_b) ? wr_data : regs[rd_sel_b];
        if (rd_sel_a == '0) rd_data_a = '0;
        if (rd_sel_b == '0) rd_data_b = '0;
    end

endmodule

`default_nettype wire

// File: rtl/cpu_pipe_pkg.sv
// ----------------------------------------
// Pipeline types for the CPU
// Decoded controls, forwarding selects and
// the four inter-stage register layouts
// ----------------------------------------
`default_nettype none

package cpu_pipe_pkg;

    // Decoded controls, travel with the instruction
    typedef struct packed {
        logic                 reg_we;        // Writes the register file
        logic                 use_imm;       // ALU B from immediate
        logic                 mem_we;        // sw
        logic                 mem_rd;        // lw, result from dmem
        logic                 is_branch_ne;
        logic                 is_branch_lt;
        logic                 is_jump;       // j and jal
        logic                 is_jal;        // Link into r31
        cpu_isa_pkg::alu_op_t alu_op;
    } ctrl_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,    // Value read in decode
        FWD_MEM = 2'd1,    // xm result
        FWD_WB  = 2'd2     // Writeback value
    } fwd_sel_t;

    // Register layouts ------------------------
    typedef struct packed {
        logic [cpu_isa_pkg::ADDR_W-1:0] pc;  // Already PC+1
        cpu_isa_pkg::instr_u            instr;
    } fd_reg_t;

    typedef struct packed {
        logic [cpu_isa_pkg::ADDR_W-1:0] pc;
        cpu_isa_pkg::instr_u            instr;
        logic [cpu_isa_pkg::XLEN-1:0]   rd_a;    // Port A, rs
        logic [cpu_isa_pkg::XLEN-1:0]   rd_b;    // Port B, rt or rd
        ctrl_t                          ctrl;
    } dx_reg_t;

    typedef struct packed {
        logic [cpu_isa_pkg::XLEN-1:0]  result;   // ALU out, also dmem address
        logic [cpu_isa_pkg::XLEN-1:0]  store_data;
        logic [cpu_isa_pkg::REG_W-1:0] dest;
        ctrl_t                         ctrl;
    } xm_reg_t;

    typedef struct packed {
        logic [cpu_isa_pkg::XLEN-1:0]  result;
        logic [cpu_isa_pkg::XLEN-1:0]  load_data;
        logic [cpu_isa_pkg::REG_W-1:0] dest;
        logic                          reg_we;
        logic                          mem_rd;   // Pick load data at writeback
    } mw_reg_t;

endpackage

`default_nettype wire

// File: rtl/cpu_isa_pkg.sv
// ----------------------------------------
// ISA definitions for the pipelined CPU
// Widths, opcodes, ALU codes and the three
// instruction formats seen through a union
// ----------------------------------------
`default_nettype none

package cpu_isa_pkg;

    localparam int XLEN   = 32;    // Data word width
    localparam int ADDR_W = 12;    // Imem and dmem address width
    localparam int NREG   = 32;    // Architectural registers
    localparam int REG_W  = 5;     // Register index width

    // Opcodes ---------------------------------
    typedef enum logic [4:0] {
        OP_ALU  = 5'b00000,        // R-type, op in alu_op field
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_JAL  = 5'b00011,
        OP_ADDI = 5'b00101,
        OP_BLT  = 5'b00110,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,            // Shift amount from shamt
        ALU_SRA = 5'd5
    } alu_op_t;

    // Formats ---------------------------------
    typedef struct packed {
        opcode_t          opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [4:0]       shamt;
        alu_op_t          alu_op;
        logic [1:0]       unused;  // Always zero in the encoder
    } r_fmt_t;

    typedef struct packed {
        opcode_t            opcode;
        logic [REG_W-1:0]   rd;    // Destination, or store/compare source
        logic [REG_W-1:0]   rs;
        logic signed [16:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [26:0] target;       // Absolute word address
    } j_fmt_t;

    // One word, decoded as R, I or J by opcode
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    localparam logic [XLEN-1:0] NOP_WORD = '0;    // add r0, r0, r0

endpackage

`default_nettype wire
